// File: source/csr_addr_pkg.sv
package csr_addr_pkg;

    localparam int unsigned xlen = 64;

    // Supported CSR addresses
    typedef enum logic [11:0] {
        csr_mstatus    = 12'h300,
        csr_misa       = 12'h301,
        csr_mie        = 12'h304,
        csr_mtvec      = 12'h305,
        csr_mcounteren = 12'h306,
        csr_mscratch   = 12'h340,
        csr_mepc       = 12'h341,
        csr_mcause     = 12'h342,
        csr_mtval      = 12'h343,
        csr_mip        = 12'h344,
        csr_mcycle     = 12'hB00,
        csr_minstret   = 12'hB02,
        csr_cycle      = 12'hC00,
        csr_instret    = 12'hC02,
        csr_mvendorid  = 12'hF11,
        csr_marchid    = 12'hF12,
        csr_mimpid     = 12'hF13
    } csr_addr_t;

    typedef enum logic [1:0] {
        op_none  = 2'b00,
        op_write = 2'b01,
        op_set   = 2'b10,
        op_clear = 2'b11
    } csr_op_t;

    // MXL = 64, extensions A, C, I, M and U
    localparam logic [63:0] misa_value = 64'h8000_0000_0010_1105;

    localparam int unsigned irq_bit_msi = 3;
    localparam int unsigned irq_bit_mti = 7;
    localparam int unsigned irq_bit_mei = 11;

    localparam logic [11:0] mie_mask       = 12'h888;
    localparam logic [2:0]  counteren_mask = 3'b101;

endpackage

// File: source/trap_pkg.sv
package trap_pkg;

    // Only machine and user modes exist
    typedef enum logic [1:0] {
        prv_u = 2'b00,
        prv_m = 2'b11
    } prv_t;

    // Fields of mstatus that this core keeps
    typedef struct packed {
        prv_t mpp;
        logic mpie;
        logic mie;
    } mstatus_t;

    typedef logic [3:0] cause_code_t;

    // Exception reported by the pipeline
    typedef struct packed {
        logic        interrupt;
        cause_code_t code;
        logic [63:0] tval;
    } exception_t;

endpackage

// File: source/csr_counter_if.sv
interface csr_counter_if
    import csr_addr_pkg::*;
();

    // Write strobe from a CSR instruction
    logic            wr;
    csr_addr_t       wsel;
    logic [xlen-1:0] wdata;

    // Current counter values
    logic [xlen-1:0] cycle;
    logic [xlen-1:0] instret;

    modport regs (
        output wr,
        output wsel,
        output wdata,
        input  cycle,
        input  instret
    );

    modport counters (
        input  wr,
        input  wsel,
        input  wdata,
        output cycle,
        output instret
    );

endinterface

// File: source/csr_access_check.sv
module csr_access_check
    import csr_addr_pkg::*;
    import trap_pkg::*;
(
    input  csr_addr_t  pc_sel,
    input  csr_op_t    pc_op,
    input  prv_t       prv,
    input  logic [2:0] mcounteren,
    output logic       pc_illegal
);

    logic unsupported;
    logic counter_denied;
    logic read_only;
    logic prv_too_low;

    // Bits 11:10 set means a read-only CSR
    assign read_only = (pc_sel[11:10] == 2'b11) && (pc_op != op_none);

    // Bits 9:8 hold the lowest privilege allowed
    assign prv_too_low = pc_sel[9:8] > prv;

    always_comb begin
        unsupported    = 1'b0;
        counter_denied = 1'b0;
        case (pc_sel)
            // User counters are gated by mcounteren
            csr_cycle:   counter_denied = (prv == prv_u) && !mcounteren[0];
            csr_instret: counter_denied = (prv == prv_u) && !mcounteren[2];
            csr_mstatus, csr_misa, csr_mie, csr_mtvec, csr_mcounteren:;
            csr_mscratch, csr_mepc, csr_mcause, csr_mtval, csr_mip:;
            csr_mcycle, csr_minstret:;
            csr_mvendorid, csr_marchid, csr_mimpid:;
            default: unsupported = 1'b1;
        endcase
    end

    assign pc_illegal = unsupported | counter_denied | read_only | prv_too_low;

endmodule

// File: source/csr_counters.sv
module csr_counters
    import csr_addr_pkg::*;
(
    input  logic     clk,
    input  logic     resetn,
    input  logic     hpm_instret,
    csr_counter_if.counters cnt
);

    logic [xlen-1:0] mcycle;
    logic [xlen-1:0] minstret;

    // A CSR write wins over the increment on the same edge
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            mcycle   <= '0;
            minstret <= '0;
        end else begin
            if (cnt.wr && cnt.wsel == csr_mcycle) begin
                mcycle <= cnt.wdata;
            end else begin
                mcycle <= mcycle + 1'b1;
            end

            if (cnt.wr && cnt.wsel == csr_minstret) begin
                minstret <= cnt.wdata;
            end else if (hpm_instret) begin
                minstret <= minstret + 1'b1;
            end
        end
    end

    assign cnt.cycle   = mcycle;
    assign cnt.instret = minstret;

endmodule

// File: source/csr_machine_regs.sv
module csr_machine_regs
    import csr_addr_pkg::*;
    import trap_pkg::*;
(
    input  logic            clk,
    input  logic            resetn,
    // CSR instruction access
    input  logic            a_valid,
    input  csr_addr_t       a_sel,
    input  csr_op_t         a_op,
    input  logic [xlen-1:0] a_data,
    output logic [xlen-1:0] a_read,
    // Trap entry
    input  logic            ex_valid,
    input  exception_t      ex_exception,
    input  logic [xlen-1:0] ex_epc,
    output logic [xlen-1:0] ex_tvec,
    // Trap return
    input  logic            er_valid,
    output logic [xlen-1:0] er_epc,
    input  logic            irq_m_external,
    input  logic            irq_m_software,
    input  logic            irq_m_timer,
    output prv_t            prv,
    output logic [2:0]      mcounteren,
    // Next-state values for the interrupt controller
    output prv_t            prv_next,
    output logic [11:0]     mie_next,
    output logic            status_mie_next,
    csr_counter_if.regs     cnt
);

    mstatus_t        status, status_d;
    prv_t            prv_d;
    logic [11:0]     mie, mie_d;
    logic [xlen-1:0] mtvec, mtvec_d;
    logic [xlen-1:0] mepc, mepc_d;
    logic [xlen-1:0] mscratch, mscratch_d;
    logic [xlen-1:0] mtval, mtval_d;
    logic            mcause_int, mcause_int_d;
    cause_code_t     mcause_code, mcause_code_d;
    logic [2:0]      mcounteren_d;

    logic [11:0]     mip;
    logic [xlen-1:0] mstatus_word;
    logic [xlen-1:0] old_value;
    logic [xlen-1:0] new_value;

    // mip reflects the live interrupt lines
    always_comb begin
        mip = '0;
        mip[irq_bit_msi] = irq_m_software;
        mip[irq_bit_mti] = irq_m_timer;
        mip[irq_bit_mei] = irq_m_external;
    end

    assign mstatus_word = {51'b0, status.mpp, 3'b0, status.mpie, 3'b0, status.mie, 3'b0};

    // Read path
    always_comb begin
        case (a_sel)
            csr_mstatus:    old_value = mstatus_word;
            csr_misa:       old_value = misa_value;
            csr_mie:        old_value = xlen'(mie);
            csr_mtvec:      old_value = mtvec;
            csr_mcounteren: old_value = xlen'(mcounteren);
            csr_mscratch:   old_value = mscratch;
            csr_mepc:       old_value = mepc;
            csr_mcause:     old_value = {mcause_int, 59'b0, mcause_code};
            csr_mtval:      old_value = mtval;
            csr_mip:        old_value = xlen'(mip);
            csr_mcycle, csr_cycle:     old_value = cnt.cycle;
            csr_minstret, csr_instret: old_value = cnt.instret;
            csr_mvendorid, csr_marchid, csr_mimpid: old_value = '0;
            default:        old_value = '0;
        endcase
    end

    assign a_read = old_value;

    always_comb begin
        case (a_op)
            op_write: new_value = a_data;
            op_set:   new_value = old_value | a_data;
            op_clear: new_value = old_value & ~a_data;
            default:  new_value = old_value;
        endcase
    end

    assign ex_tvec = mtvec;
    assign er_epc  = mepc;

    // Trap entry, then trap return, then CSR write
    always_comb begin
        prv_d         = prv;
        status_d      = status;
        mie_d         = mie;
        mtvec_d       = mtvec;
        mepc_d        = mepc;
        mscratch_d    = mscratch;
        mtval_d       = mtval;
        mcause_int_d  = mcause_int;
        mcause_code_d = mcause_code;
        mcounteren_d  = mcounteren;
        cnt.wr        = 1'b0;

        if (ex_valid) begin
            mepc_d          = ex_epc;
            mcause_int_d    = ex_exception.interrupt;
            mcause_code_d   = ex_exception.code;
            mtval_d         = ex_exception.tval;
            status_d.mpie   = status.mie;
            status_d.mie    = 1'b0;
            status_d.mpp    = prv;
            prv_d           = prv_m;
        end else if (er_valid) begin
            prv_d           = status.mpp;
            status_d.mie    = status.mpie;
            status_d.mpie   = 1'b1;
            status_d.mpp    = prv_u;
        end else if (a_valid && a_op != op_none) begin
            // Counters take the same strobe and pick their own address
            cnt.wr = 1'b1;
            case (a_sel)
                csr_mstatus: begin
                    // Reserved mpp encodings leave the field unchanged
                    if (new_value[12:11] == prv_u || new_value[12:11] == prv_m) begin
                        status_d.mpp = prv_t'(new_value[12:11]);
                    end
                    status_d.mpie = new_value[7];
                    status_d.mie  = new_value[3];
                end
                csr_mie:        mie_d = new_value[11:0] & mie_mask;
                csr_mtvec:      mtvec_d = {new_value[xlen-1:2], 2'b0};
                csr_mcounteren: mcounteren_d = new_value[2:0] & counteren_mask;
                csr_mscratch:   mscratch_d = new_value;
                csr_mepc:       mepc_d = {new_value[xlen-1:1], 1'b0};
                csr_mcause: begin
                    mcause_int_d  = new_value[xlen-1];
                    mcause_code_d = new_value[3:0];
                end
                csr_mtval:      mtval_d = new_value;
                default:;
            endcase
        end
    end

    assign cnt.wsel  = a_sel;
    assign cnt.wdata = new_value;

    assign prv_next        = prv_d;
    assign mie_next        = mie_d;
    assign status_mie_next = status_d.mie;

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            prv         <= prv_m;
            status      <= '{mpp: prv_u, mpie: 1'b0, mie: 1'b0};
            mie         <= '0;
            mtvec       <= '0;
            mepc        <= '0;
            mscratch    <= '0;
            mtval       <= '0;
            mcause_int  <= 1'b0;
            mcause_code <= '0;
            mcounteren  <= '0;
        end else begin
            prv         <= prv_d;
            status      <= status_d;
            mie         <= mie_d;
            mtvec       <= mtvec_d;
            mepc        <= mepc_d;
            mscratch    <= mscratch_d;
            mtval       <= mtval_d;
            mcause_int  <= mcause_int_d;
            mcause_code <= mcause_code_d;
            mcounteren  <= mcounteren_d;
        end
    end

    // Pipeline never raises a trap and a return together
    trap_and_return_exclusive: assert property (
        @(posedge clk) disable iff (!resetn) !(ex_valid && er_valid)
    );

    // The pipeline issues mret only in M-mode
    mret_from_machine: assert property (
        @(posedge clk) disable iff (!resetn) er_valid |-> prv == prv_m
    );

endmodule

// File: source/csr_irq_ctrl.sv
module csr_irq_ctrl
    import csr_addr_pkg::*;
    import trap_pkg::*;
(
    input  logic        clk,
    input  logic        resetn,
    input  logic        irq_m_external,
    input  logic        irq_m_software,
    input  logic        irq_m_timer,
    input  prv_t        prv_next,
    input  logic [11:0] mie_next,
    input  logic        status_mie_next,
    output logic        int_valid,
    output cause_code_t int_cause,
    output logic        wfi_valid
);

    logic [11:0] lines;
    logic [11:0] pending;
    logic        take;
    cause_code_t cause_d;

    always_comb begin
        lines = '0;
        lines[irq_bit_msi] = irq_m_software;
        lines[irq_bit_mti] = irq_m_timer;
        lines[irq_bit_mei] = irq_m_external;
    end

    // Enabled lines, regardless of the global enable
    assign pending = lines & mie_next;

    // U-mode is always interruptible
    assign take = (prv_next == prv_u) || status_mie_next;

    always_comb begin
        if (pending[irq_bit_mei]) begin
            cause_d = cause_code_t'(irq_bit_mei);
        end else if (pending[irq_bit_msi]) begin
            cause_d = cause_code_t'(irq_bit_msi);
        end else begin
            cause_d = cause_code_t'(irq_bit_mti);
        end
    end

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            int_valid <= 1'b0;
            int_cause <= '0;
            wfi_valid <= 1'b0;
        end else begin
            int_valid <= (|pending) && take;
            int_cause <= cause_d;
            wfi_valid <= |pending;
        end
    end

    // Interrupt lines carry known levels once out of reset
    irq_lines_known: assert property (
        @(posedge clk) disable iff (!resetn)
            !$isunknown({irq_m_external, irq_m_software, irq_m_timer})
    );

endmodule

// File: source/csr_trap_unit.sv
module csr_trap_unit
    import csr_addr_pkg::*;
    import trap_pkg::*;
(
    input  logic            clk,
    input  logic            resetn,
    input  csr_addr_t       pc_sel,
    input  csr_op_t         pc_op,
    output logic            pc_illegal,
    input  logic            a_valid,
    input  csr_addr_t       a_sel,
    input  csr_op_t         a_op,
    input  logic [xlen-1:0] a_data,
    output logic [xlen-1:0] a_read,
    input  logic            ex_valid,
    input  exception_t      ex_exception,
    input  logic [xlen-1:0] ex_epc,
    output logic [xlen-1:0] ex_tvec,
    input  logic            er_valid,
    output logic [xlen-1:0] er_epc,
    input  logic            irq_m_external,
    input  logic            irq_m_software,
    input  logic            irq_m_timer,
    output logic            int_valid,
    output cause_code_t     int_cause,
    output logic            wfi_valid,
    input  logic            hpm_instret
);

    prv_t        prv;
    prv_t        prv_next;
    logic [2:0]  mcounteren;
    logic [11:0] mie_next;
    logic        status_mie_next;

    csr_counter_if cnt_if ();

    csr_access_check u_access_check (
        .pc_sel     (pc_sel),
        .pc_op      (pc_op),
        .prv        (prv),
        .mcounteren (mcounteren),
        .pc_illegal (pc_illegal)
    );

    csr_machine_regs u_machine_regs (
        .clk             (clk),
        .resetn          (resetn),
        .a_valid         (a_valid),
        .a_sel           (a_sel),
        .a_op            (a_op),
        .a_data          (a_data),
        .a_read          (a_read),
        .ex_valid        (ex_valid),
        .ex_exception    (ex_exception),
        .ex_epc          (ex_epc),
        .ex_tvec         (ex_tvec),
        .er_valid        (er_valid),
        .er_epc          (er_epc),
        .irq_m_external  (irq_m_external),
        .irq_m_software  (irq_m_software),
        .irq_m_timer     (irq_m_timer),
        .prv             (prv),
        .mcounteren      (mcounteren),
        .prv_next        (prv_next),
        .mie_next        (mie_next),
        .status_mie_next (status_mie_next),
        .cnt             (cnt_if.regs)
    );

    csr_counters u_counters (
        .clk         (clk),
        .resetn      (resetn),
        .hpm_instret (hpm_instret),
        .cnt         (cnt_if.counters)
    );

    csr_irq_ctrl u_irq_ctrl (
        .clk             (clk),
        .resetn          (resetn),
        .irq_m_external  (irq_m_external),
        .irq_m_software  (irq_m_software),
        .irq_m_timer     (irq_m_timer),
        .prv_next        (prv_next),
        .mie_next        (mie_next),
        .status_mie_next (status_mie_next),
        .int_valid       (int_valid),
        .int_cause       (int_cause),
        .wfi_valid       (wfi_valid)
    );

endmodule

// File: test/tb_csr_trap.sv
module tb_csr_trap
    import csr_addr_pkg::*;
    import trap_pkg::*;
();

    localparam int    reset_cycles    = 10;
    localparam int    cycles_per_test = 40;
    localparam int    drive_delay     = 2;
    localparam string golden_path     = "test/csr_golden.txt";

    logic            clk;
    logic            resetn;
    csr_addr_t       pc_sel;
    csr_op_t         pc_op;
    logic            pc_illegal;
    logic            a_valid;
    csr_addr_t       a_sel;
    csr_op_t         a_op;
    logic [xlen-1:0] a_data;
    logic [xlen-1:0] a_read;
    logic            ex_valid;
    exception_t      ex_exception;
    logic [xlen-1:0] ex_epc;
    logic [xlen-1:0] ex_tvec;
    logic            er_valid;
    logic [xlen-1:0] er_epc;
    logic            irq_m_external;
    logic            irq_m_software;
    logic            irq_m_timer;
    logic            int_valid;
    cause_code_t     int_cause;
    logic            wfi_valid;
    logic            hpm_instret;

    // Test table loaded from the golden file
    string       names[$];
    string       kinds[$];
    logic [63:0] addrs[$];
    logic [63:0] values[$];
    logic [63:0] expects[$];

    int pass_count = 0;
    int fail_count = 0;
    int cycle_count = 0;
    int cycle_limit = 1000;

    csr_trap_unit dut (
        .clk            (clk),
        .resetn         (resetn),
        .pc_sel         (pc_sel),
        .pc_op          (pc_op),
        .pc_illegal     (pc_illegal),
        .a_valid        (a_valid),
        .a_sel          (a_sel),
        .a_op           (a_op),
        .a_data         (a_data),
        .a_read         (a_read),
        .ex_valid       (ex_valid),
        .ex_exception   (ex_exception),
        .ex_epc         (ex_epc),
        .ex_tvec        (ex_tvec),
        .er_valid       (er_valid),
        .er_epc         (er_epc),
        .irq_m_external (irq_m_external),
        .irq_m_software (irq_m_software),
        .irq_m_timer    (irq_m_timer),
        .int_valid      (int_valid),
        .int_cause      (int_cause),
        .wfi_valid      (wfi_valid),
        .hpm_instret    (hpm_instret)
    );

    always #20 clk = ~clk;

    // Run limit
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("Timeout: run did not finish within %0d cycles", cycle_limit);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    task automatic load_tests();
        int          fd;
        int          count;
        string       line;
        string       name;
        string       kind;
        logic [63:0] addr;
        logic [63:0] value;
        logic [63:0] expected;
        fd = $fopen(golden_path, "r");
        if (fd == 0) begin
            $display("Cannot open golden file %s", golden_path);
            fail_count++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                count = $fgets(line, fd);
                // Skip blank lines and comment lines
                if (count == 0 || line.len() < 2 || line[0] == "#") begin
                    continue;
                end
                count = $sscanf(line, "%s %s %h %h %h", name, kind, addr, value, expected);
                if (count != 5) begin
                    $display("Malformed line in golden file: %s", line);
                    fail_count++;
                end else begin
                    names.push_back(name);
                    kinds.push_back(kind);
                    addrs.push_back(addr);
                    values.push_back(value);
                    expects.push_back(expected);
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic report_value(input string name, input logic [63:0] expected,
                                input logic [63:0] actual);
        if (actual !== expected) begin
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
            fail_count++;
        end else begin
            $display("Pass %s", name);
            pass_count++;
        end
    endtask

    // Pulses end here, the interrupt lines keep their level
    task automatic idle_inputs();
        a_valid     = 1'b0;
        a_op        = op_none;
        pc_op       = op_none;
        ex_valid    = 1'b0;
        er_valid    = 1'b0;
        hpm_instret = 1'b0;
    endtask

    // One write, set or clear, then read the same CSR after the edge
    task automatic access_csr(input string name, input csr_op_t op, input logic [63:0] addr,
                              input logic [63:0] value, input logic [63:0] expected);
        @(posedge clk);
        #drive_delay;
        idle_inputs();
        a_valid = 1'b1;
        a_sel   = csr_addr_t'(addr[11:0]);
        a_op    = op;
        a_data  = value;
        @(posedge clk);
        #drive_delay;
        idle_inputs();
        @(negedge clk);
        report_value(name, expected, a_read);
    endtask

    task automatic read_csr(input string name, input logic [63:0] addr,
                            input logic [63:0] expected);
        @(posedge clk);
        #drive_delay;
        idle_inputs();
        a_sel = csr_addr_t'(addr[11:0]);
        @(negedge clk);
        report_value(name, expected, a_read);
    endtask

    task automatic check_privilege(input string name, input logic [63:0] addr,
                                   input logic [63:0] op, input logic [63:0] expected);
        @(posedge clk);
        #drive_delay;
        idle_inputs();
        pc_sel = csr_addr_t'(addr[11:0]);
        pc_op  = csr_op_t'(op[1:0]);
        @(negedge clk);
        report_value(name, expected, {63'b0, pc_illegal});
    endtask

    // The faulting pc goes to mepc and pc + 2 to mtval
    task automatic raise_trap(input string name, input logic [63:0] cause,
                              input logic [63:0] pc, input logic [63:0] expected);
        @(posedge clk);
        #drive_delay;
        idle_inputs();
        ex_valid               = 1'b1;
        ex_exception.interrupt = 1'b0;
        ex_exception.code      = cause[3:0];
        ex_exception.tval      = pc + 64'd2;
        ex_epc                 = pc;
        @(negedge clk);
        report_value(name, expected, ex_tvec);
        @(posedge clk);
        #drive_delay;
        idle_inputs();
    endtask

    task automatic return_from_trap(input string name, input logic [63:0] expected);
        @(posedge clk);
        #drive_delay;
        idle_inputs();
        er_valid = 1'b1;
        @(negedge clk);
        report_value(name, expected, er_epc);
        @(posedge clk);
        #drive_delay;
        idle_inputs();
    endtask

    // Lines use the mip bit layout, the result packs int_valid, wfi_valid and int_cause
    task automatic drive_irq_lines(input string name, input logic [63:0] lines,
                                   input logic [63:0] expected);
        @(posedge clk);
        #drive_delay;
        idle_inputs();
        irq_m_software = lines[irq_bit_msi];
        irq_m_timer    = lines[irq_bit_mti];
        irq_m_external = lines[irq_bit_mei];
        @(posedge clk);
        @(negedge clk);
        report_value(name, expected, {55'b0, int_valid, 3'b0, wfi_valid, int_cause});
    endtask

    task automatic count_instret(input string name, input logic [63:0] addr,
                                 input logic [63:0] count, input logic [63:0] expected);
        @(posedge clk);
        #drive_delay;
        idle_inputs();
        a_sel       = csr_addr_t'(addr[11:0]);
        hpm_instret = 1'b1;
        repeat (int'(count)) @(posedge clk);
        #drive_delay;
        hpm_instret = 1'b0;
        @(negedge clk);
        report_value(name, expected, a_read);
    endtask

    task automatic run_test(input int idx);
        case (kinds[idx])
            "write":   access_csr(names[idx], op_write, addrs[idx], values[idx], expects[idx]);
            "set":     access_csr(names[idx], op_set, addrs[idx], values[idx], expects[idx]);
            "clear":   access_csr(names[idx], op_clear, addrs[idx], values[idx], expects[idx]);
            "read":    read_csr(names[idx], addrs[idx], expects[idx]);
            "check":   check_privilege(names[idx], addrs[idx], values[idx], expects[idx]);
            "trap":    raise_trap(names[idx], addrs[idx], values[idx], expects[idx]);
            "mret":    return_from_trap(names[idx], expects[idx]);
            "irq":     drive_irq_lines(names[idx], values[idx], expects[idx]);
            "instret": count_instret(names[idx], addrs[idx], values[idx], expects[idx]);
            default: begin
                $display("Test %s has unknown kind %s", names[idx], kinds[idx]);
                fail_count++;
            end
        endcase
    endtask

    initial begin
        clk            = 1'b0;
        resetn         = 1'b0;
        pc_sel         = csr_mstatus;
        pc_op          = op_none;
        a_valid        = 1'b0;
        a_sel          = csr_mstatus;
        a_op           = op_none;
        a_data         = '0;
        ex_valid       = 1'b0;
        ex_exception   = '0;
        ex_epc         = '0;
        er_valid       = 1'b0;
        irq_m_external = 1'b0;
        irq_m_software = 1'b0;
        irq_m_timer    = 1'b0;
        hpm_instret    = 1'b0;

        load_tests();
        cycle_limit = cycles_per_test * names.size() + reset_cycles;

        repeat (reset_cycles) @(posedge clk);
        #drive_delay;
        resetn = 1'b1;

        for (int i = 0; i < names.size(); i++) begin
            run_test(i);
        end

        $display("Tests run: %0d, passed: %0d, failed: %0d",
                 names.size(), pass_count, fail_count);
        if (fail_count == 0 && pass_count > 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: test/csr_golden.txt
# Columns: name kind addr_or_cause value expected, numbers in hex
# trap sets mtval to pc + 2, irq expects digits int_valid wfi_valid int_cause
mscratch_write write 340 123456789abcdef0 123456789abcdef0
mscratch_set set 340 0f0f 123456789abcdfff
mscratch_clear clear 340 ff00000000000000 003456789abcdfff
mie_mask write 304 ffffffffffffffff 888
mtvec_align write 305 80001003 80001000
misa_read read 301 0 8000000000101105
misa_write_ignored write 301 0 8000000000101105
mvendorid_read read f11 0 0
mvendorid_write_flag check f11 1 1
unsupported_flag check 7c0 0 1
mstatus_machine_legal check 300 0 0
mepc_align write 341 80000201 80000200
mret_to_user mret 0 0 80000200
mstatus_after_mret read 300 0 80
user_mstatus_flag check 300 0 1
user_cycle_flag check c00 0 1
mcounteren_mask write 306 7 5
user_cycle_legal check c00 0 0
user_instret_legal check c02 0 0
trap_from_user trap 2 80000400 80001000
prv_after_trap check 300 0 0
mepc_after_trap read 341 0 80000400
mcause_after_trap read 342 0 2
mtval_after_trap read 343 0 80000402
mstatus_after_trap read 300 0 0
mstatus_mpp_machine write 300 1880 1880
mret_to_machine mret 0 0 80000400
prv_after_mret check 300 0 0
mstatus_mie_restored read 300 0 88
irq_timer irq 0 80 117
irq_external irq 0 880 11b
irq_release irq 0 0 007
mstatus_mie_off clear 300 8 80
irq_timer_masked irq 0 80 017
irq_release_masked irq 0 0 007
mcycle_write write b00 1000 1000
mcycle_next read b00 0 1001
minstret_write write b02 0 0
minstret_count instret b02 5 5
minstret_hold read b02 0 5

// File: list.f
source/csr_addr_pkg.sv
source/trap_pkg.sv
source/csr_counter_if.sv
source/csr_access_check.sv
source/csr_counters.sv
source/csr_machine_regs.sv
source/csr_irq_ctrl.sv
source/csr_trap_unit.sv
test/tb_csr_trap.sv

// File: run.sh
#!/bin/sh
# Build and run the CSR trap unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f list.f \
    --top-module tb_csr_trap -o sim_csr_trap
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/sim_csr_trap > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "RESULT: PASS" "$LOG"; then
    exit 0
fi
echo "Pass line not found in $LOG"
exit 1
